/* design/fsl_accel_pkg.sv */
// Shared link word layout, opcodes, state codes and reduction constants, imported by every RTL block.
package fsl_accel_pkg;

	// Width of the data part of one link word.
	// The control bit travels beside it and is not counted here.
	localparam int fsl_data_width = 32;

	// Width of the packet length field in a command header.
	localparam int fsl_len_width = 16;

	// Width of the opcode field in a command header.
	localparam int fsl_op_width = 8;

	// Supported reductions.
	// Any opcode above op_max is rejected by the sequencer.
	localparam logic [fsl_op_width-1:0] op_sum = 8'd0;
	localparam logic [fsl_op_width-1:0] op_xor = 8'd1;
	localparam logic [fsl_op_width-1:0] op_max = 8'd2;

	// Starting value of the accumulator for every operation.
	// Zero is neutral for sum and XOR, and for an unsigned maximum it is the lowest value.
	localparam logic [fsl_data_width-1:0] red_identity = '0;

	// Sequencer states.
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_collect = 2'd1;
	localparam logic [1:0] st_emit = 2'd2;

	// Header view of a link word, valid when the control bit is set.
	// The spare byte is ignored by the hardware.
	typedef struct packed {
		logic [fsl_op_width-1:0] opcode;
		logic [7:0] spare;
		logic [fsl_len_width-1:0] length;
	} fsl_header_t;

	// One link word seen either as a header or as plain data.
	// The control bit beside the word selects which view is meaningful.
	typedef union packed {
		fsl_header_t header;
		logic [fsl_data_width-1:0] raw;
	} fsl_word_u;

	// Error results are sent with the control bit set.
	// For an unknown opcode the result data is the rejected header word itself.
	// For a header that aborts an open packet the result data is the partial reduction.

endpackage

/* design/fsl_link.sv */
// One-deep, one-way simplex link buffer between a single writer and a single reader.
`timescale 1ns/1ps

module fsl_link (
	input  logic clock,
	input  logic reset,
	input  logic [fsl_accel_pkg::fsl_data_width-1:0] m_data,
	input  logic m_control,
	input  logic m_write,
	output logic m_full,
	output logic [fsl_accel_pkg::fsl_data_width-1:0] s_data,
	output logic s_control,
	output logic s_exists,
	input  logic s_read
);

	import fsl_accel_pkg::*;

	// Stored word with the control bit on top.
	logic [fsl_data_width:0] word_q;

	// Occupancy of the single slot.
	logic exists_q;

	// The slot is either empty or full, so one flag serves both sides.
	assign m_full = exists_q;
	assign s_exists = exists_q;

	// The reader sees the stored word directly.
	assign s_data = word_q[fsl_data_width-1:0];
	assign s_control = word_q[fsl_data_width];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			word_q <= '0;
			exists_q <= 1'b0;
		end
		else
		begin
			// A write captures the word and its control bit.
			if (m_write)
			begin
				word_q <= {m_control, m_data};
			end
			// A read empties the slot and wins over a write in the same cycle.
			if (s_read)
			begin
				exists_q <= 1'b0;
			end
			else if (m_write)
			begin
				exists_q <= 1'b1;
			end
		end
	end

	// The writer must respect full and the reader must respect exists.
	a_no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		m_write |-> !m_full);
	a_no_read_when_empty: assert property (@(posedge clock) disable iff (reset)
		s_read |-> s_exists);

endmodule

/* design/fsl_reduce_unit.sv */
// Accumulator that folds the data words of one packet by sum, XOR or unsigned maximum.
`timescale 1ns/1ps

module fsl_reduce_unit (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic [fsl_accel_pkg::fsl_op_width-1:0] opcode,
	input  logic data_valid,
	input  logic [fsl_accel_pkg::fsl_data_width-1:0] data,
	output logic [fsl_accel_pkg::fsl_data_width-1:0] acc
);

	import fsl_accel_pkg::*;

	// Operation of the open packet, captured when it starts.
	logic [fsl_op_width-1:0] op_q;

	// Incoming link word in its data view.
	fsl_word_u in_word;

	// Next accumulator value if the current word is folded in.
	logic [fsl_data_width-1:0] fold;

	always_comb
	begin
		in_word.raw = data;
		case (op_q)
			op_sum:
			begin
				// Carry out of bit 31 is simply lost.
				fold = acc + in_word.raw;
			end
			op_xor:
			begin
				fold = acc ^ in_word.raw;
			end
			op_max:
			begin
				// Both operands are compared as unsigned numbers.
				fold = (in_word.raw > acc) ? in_word.raw : acc;
			end
			default:
			begin
				// The sequencer never starts an unknown operation.
				fold = acc;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			op_q <= op_sum;
			acc <= red_identity;
		end
		else if (start)
		begin
			// A new packet clears the previous result.
			op_q <= opcode;
			acc <= red_identity;
		end
		else if (data_valid)
		begin
			acc <= fold;
		end
	end

	// The sequencer starts a packet only from idle and feeds data only while collecting.
	a_start_not_with_data: assert property (@(posedge clock) disable iff (reset)
		!(start && data_valid));

endmodule

/* design/fsl_accel_ctrl.sv */
// Packet sequencer that reads headers and data from the inbound link and writes one result per packet.
`timescale 1ns/1ps

module fsl_accel_ctrl (
	input  logic clock,
	input  logic reset,
	input  logic [fsl_accel_pkg::fsl_data_width-1:0] in_data,
	input  logic in_control,
	input  logic in_exists,
	output logic in_read,
	output logic [fsl_accel_pkg::fsl_data_width-1:0] out_data,
	output logic out_control,
	output logic out_write,
	input  logic out_full,
	output logic red_start,
	output logic [fsl_accel_pkg::fsl_op_width-1:0] red_opcode,
	output logic red_valid,
	output logic [fsl_accel_pkg::fsl_data_width-1:0] red_data,
	input  logic [fsl_accel_pkg::fsl_data_width-1:0] red_acc
);

	import fsl_accel_pkg::*;

	// Control state.
	logic [1:0] state;
	logic [fsl_len_width-1:0] count;
	logic result_err;
	logic pend_valid;

	// Payload held for an error result and for an aborting header.
	logic [fsl_data_width-1:0] err_data;
	logic [fsl_data_width-1:0] pend_word;

	// Word presented to the header decoder in idle.
	fsl_word_u dec_word;
	logic dec_control;
	logic dec_avail;
	logic op_ok;

	// Header accepted in idle, and header that breaks an open packet.
	logic hdr_seen;
	logic abort;

	// A header remembered from an abort is decoded before anything new is read.
	always_comb
	begin
		dec_word.raw = pend_valid ? pend_word : in_data;
		dec_control = pend_valid | in_control;
		dec_avail = pend_valid | in_exists;
		op_ok = (dec_word.header.opcode == op_sum) ||
			(dec_word.header.opcode == op_xor) ||
			(dec_word.header.opcode == op_max);
	end

	assign hdr_seen = (state == st_idle) && dec_avail && dec_control;
	assign abort = (state == st_collect) && in_exists && in_control;

	// Reading stops in emit, which lets a full outbound link push back on the host.
	// Idle also waits while a remembered header is still to be decoded.
	assign in_read = in_exists &&
		(((state == st_idle) && !pend_valid) || (state == st_collect));

	// Reduce unit controls.
	assign red_start = hdr_seen && op_ok;
	assign red_opcode = dec_word.header.opcode;
	assign red_valid = (state == st_collect) && in_exists && !in_control;
	assign red_data = in_data;

	// Normal results come straight from the accumulator.
	// It settles at the edge that consumes the last word, one cycle before the write.
	assign out_write = (state == st_emit) && !out_full;
	assign out_data = result_err ? err_data : red_acc;
	assign out_control = result_err;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			count <= '0;
			result_err <= 1'b0;
			pend_valid <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					// Plain data words in idle are read and dropped.
					if (hdr_seen)
					begin
						pend_valid <= 1'b0;
						if (op_ok)
						begin
							result_err <= 1'b0;
							count <= dec_word.header.length;
							// An empty packet reports the identity value at once.
							if (dec_word.header.length == '0)
								state <= st_emit;
							else
								state <= st_collect;
						end
						else
						begin
							result_err <= 1'b1;
							state <= st_emit;
						end
					end
				end
				st_collect:
				begin
					if (abort)
					begin
						// Report the partial result and keep the header for later.
						result_err <= 1'b1;
						pend_valid <= 1'b1;
						state <= st_emit;
					end
					else if (in_exists)
					begin
						count <= count - 1'b1;
						if (count == 1)
							state <= st_emit;
					end
				end
				st_emit:
				begin
					// Hold the result until the outbound slot is free.
					if (!out_full)
						state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// The error payload and the aborting header are loaded when the error is detected.
	always_ff @(posedge clock)
	begin
		if (hdr_seen && !op_ok)
		begin
			err_data <= dec_word.raw;
		end
		else if (abort)
		begin
			err_data <= red_acc;
			pend_word <= in_data;
		end
	end

	// An open packet always has at least one data word still to take.
	a_collect_count: assert property (@(posedge clock) disable iff (reset)
		(state == st_collect) |-> (count != '0));

endmodule

/* design/fsl_accel_top.sv */
// Accelerator top level with an inbound link from the host and an outbound link for results.
`timescale 1ns/1ps

module fsl_accel_top (
	input  logic clock,
	input  logic reset,
	input  logic [fsl_accel_pkg::fsl_data_width-1:0] in_data,
	input  logic in_control,
	input  logic in_write,
	output logic in_full,
	output logic [fsl_accel_pkg::fsl_data_width-1:0] out_data,
	output logic out_control,
	output logic out_exists,
	input  logic out_read
);

	import fsl_accel_pkg::*;

	// Reader side of the inbound link.
	logic [fsl_data_width-1:0] req_data;
	logic req_control;
	logic req_exists;
	logic req_read;

	// Writer side of the outbound link.
	logic [fsl_data_width-1:0] res_data;
	logic res_control;
	logic res_write;
	logic res_full;

	// Sequencer to reduce unit.
	logic red_start;
	logic [fsl_op_width-1:0] red_opcode;
	logic red_valid;
	logic [fsl_data_width-1:0] red_data;
	logic [fsl_data_width-1:0] red_acc;

	// The host writes commands and data here.
	fsl_link in_link (
		.clock     (clock),
		.reset     (reset),
		.m_data    (in_data),
		.m_control (in_control),
		.m_write   (in_write),
		.m_full    (in_full),
		.s_data    (req_data),
		.s_control (req_control),
		.s_exists  (req_exists),
		.s_read    (req_read)
	);

	fsl_accel_ctrl ctrl (
		.clock       (clock),
		.reset       (reset),
		.in_data     (req_data),
		.in_control  (req_control),
		.in_exists   (req_exists),
		.in_read     (req_read),
		.out_data    (res_data),
		.out_control (res_control),
		.out_write   (res_write),
		.out_full    (res_full),
		.red_start   (red_start),
		.red_opcode  (red_opcode),
		.red_valid   (red_valid),
		.red_data    (red_data),
		.red_acc     (red_acc)
	);

	fsl_reduce_unit reduce (
		.clock      (clock),
		.reset      (reset),
		.start      (red_start),
		.opcode     (red_opcode),
		.data_valid (red_valid),
		.data       (red_data),
		.acc        (red_acc)
	);

	// The host drains results from here.
	fsl_link out_link (
		.clock     (clock),
		.reset     (reset),
		.m_data    (res_data),
		.m_control (res_control),
		.m_write   (res_write),
		.m_full    (res_full),
		.s_data    (out_data),
		.s_control (out_control),
		.s_exists  (out_exists),
		.s_read    (out_read)
	);

endmodule

/* tb/fsl_accel_tb.sv */
// Self-checking testbench for the accelerator top level, compiled as the simulation top from the file list.
`timescale 1ns/1ps

module fsl_accel_tb;

	import fsl_accel_pkg::*;

	logic clock;
	logic reset;
	logic [fsl_data_width-1:0] in_data;
	logic in_control;
	logic in_write;
	logic in_full;
	logic [fsl_data_width-1:0] out_data;
	logic out_control;
	logic out_exists;
	logic out_read;

	// Expected results with the control bit on top, oldest first.
	logic [fsl_data_width:0] expect_q[$];
	logic exp_valid;
	logic [fsl_data_width-1:0] exp_data;
	logic exp_control;

	// Host-side model of the packet that is open in the accelerator.
	logic model_open;
	logic [fsl_op_width-1:0] model_op;
	logic [fsl_data_width-1:0] model_acc;
	int model_left;

	integer seed;
	int words_sent;
	int results_expected;
	int results_seen;
	int cycles;
	int op_pick;
	int len_pick;
	logic pause_reads;
	logic wrote_any;

	fsl_accel_top fsl_accel_top_i (
		.clock       (clock),
		.reset       (reset),
		.in_data     (in_data),
		.in_control  (in_control),
		.in_write    (in_write),
		.in_full     (in_full),
		.out_data    (out_data),
		.out_control (out_control),
		.out_exists  (out_exists),
		.out_read    (out_read)
	);

	always #50 clock = ~clock;

	task automatic halt_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	// Reduction rules: sum wraps at 32 bits, maximum compares unsigned.
	function automatic logic [31:0] fold_word(input logic [7:0] op, input logic [31:0] acc,
		input logic [31:0] d);
		case (op)
			op_sum: fold_word = acc + d;
			op_xor: fold_word = acc ^ d;
			default: fold_word = (d > acc) ? d : acc;
		endcase
	endfunction

	task automatic expect_result(input logic ctrl, input logic [31:0] data);
		expect_q.push_back({ctrl, data});
		results_expected++;
	endtask

	// Writes one word into the inbound link once it has room.
	// Every call starts 1 ns after a rising edge, so in_full is settled when it is tested.
	task automatic drive_word(input logic ctrl, input logic [31:0] data);
		@(posedge clock);
		#1;
		while (in_full)
		begin
			@(posedge clock);
			#1;
		end
		in_data = data;
		in_control = ctrl;
		in_write = 1'b1;
		@(posedge clock);
		#1;
		in_write = 1'b0;
		words_sent++;
	endtask

	task automatic send_header(input logic [7:0] op, input int len);
		fsl_word_u hdr;
		hdr.header.opcode = op;
		hdr.header.spare = 8'($random(seed));
		hdr.header.length = 16'(len);
		// A header inside an open packet closes it with the partial result as an error.
		if (model_open)
		begin
			expect_result(1'b1, model_acc);
			model_open = 1'b0;
		end
		if (op > op_max)
			expect_result(1'b1, hdr.raw);
		else if (len == 0)
			expect_result(1'b0, '0);
		else
		begin
			model_open = 1'b1;
			model_op = op;
			model_acc = '0;
			model_left = len;
		end
		drive_word(1'b1, hdr.raw);
	endtask

	task automatic send_data();
		logic [31:0] d;
		d = $random(seed);
		// Data outside a packet is dropped by the accelerator.
		if (model_open)
		begin
			model_acc = fold_word(model_op, model_acc, d);
			model_left--;
			if (model_left == 0)
			begin
				expect_result(1'b0, model_acc);
				model_open = 1'b0;
			end
		end
		drive_word(1'b0, d);
	endtask

	task automatic send_packet(input logic [7:0] op, input int len);
		int k;
		send_header(op, len);
		for (k = 0; k < len; k++)
			send_data();
	endtask

	task automatic drain_results();
		while (expect_q.size() != 0 || out_exists)
			@(posedge clock);
		repeat (20) @(posedge clock);
	endtask

	// Host side of the outbound link, which reads whenever a result waits and reads are allowed.
	always @(posedge clock)
	begin
		#1;
		if (out_read)
		begin
			void'(expect_q.pop_front());
			results_seen++;
		end
		out_read = out_exists && !pause_reads && !reset;
	end

	// The queue head is refreshed between edges so the checks see it stable.
	always @(negedge clock)
	begin
		exp_valid = (expect_q.size() != 0);
		if (exp_valid)
			{exp_control, exp_data} = expect_q[0];
	end

	always @(posedge clock)
	begin
		if (in_write)
			wrote_any <= 1'b1;
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles > 40 * words_sent + 500)
			halt_with_error("Timeout: the run took more cycles than the words sent allow.");
	end

	a_result_expected: assert property (@(posedge clock) disable iff (reset)
		out_read |-> exp_valid)
		else halt_with_error($sformatf("A result arrived at %0t ns with none expected.", $time));
	a_result_data: assert property (@(posedge clock) disable iff (reset)
		out_read && exp_valid |-> out_data == exp_data)
		else halt_with_error($sformatf("mismatch at %0t ns: out_data expected %h, got %h",
			$time, exp_data, out_data));
	a_result_control: assert property (@(posedge clock) disable iff (reset)
		out_read && exp_valid |-> out_control == exp_control)
		else halt_with_error($sformatf("mismatch at %0t ns: out_control expected %b, got %b",
			$time, exp_control, out_control));
	// Before the first write both links are empty.
	a_quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
		!wrote_any |-> !in_full && !out_exists)
		else halt_with_error("A link flag went high before anything was written.");
	// A host write fills the inbound slot, since the sequencer never reads an empty link.
	a_in_link_fills: assert property (@(posedge clock) disable iff (reset)
		in_write |=> in_full)
		else halt_with_error("The inbound link did not turn full after a host write.");
	// A waiting result stays in the outbound slot unchanged until the host reads it.
	a_out_link_holds: assert property (@(posedge clock) disable iff (reset)
		out_exists && !out_read |=> out_exists && $stable(out_data) && $stable(out_control))
		else halt_with_error("A waiting result left or changed before the host read it.");

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		in_data = '0;
		in_control = 1'b0;
		in_write = 1'b0;
		out_read = 1'b0;
		pause_reads = 1'b0;
		wrote_any = 1'b0;
		model_open = 1'b0;
		exp_valid = 1'b0;
		exp_data = '0;
		exp_control = 1'b0;
		seed = 32'h9f1e_1b41;
		words_sent = 0;
		results_expected = 0;
		results_seen = 0;
		cycles = 0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (10) @(posedge clock);
		// One packet per operation, then empty packets that must report zero.
		send_packet(op_sum, 3);
		send_packet(op_xor, 4);
		send_packet(op_max, 5);
		send_packet(op_sum, 0);
		send_packet(op_xor, 0);
		send_packet(op_max, 0);
		for (int p = 0; p < 12; p++)
		begin
			op_pick = $unsigned($random(seed)) % 3;
			len_pick = $unsigned($random(seed)) % 12 + 1;
			send_packet(8'(op_pick), len_pick);
		end
		// Unknown opcodes echo the header, and the data after them is dropped.
		send_header(8'd3, 2);
		send_data();
		send_data();
		send_header(8'hff, 0);
		send_header(8'h80, 5);
		// Stray data in idle, then headers that cut open packets short.
		send_data();
		send_header(op_sum, 5);
		send_data();
		send_data();
		send_packet(op_xor, 3);
		send_header(op_max, 4);
		send_data();
		send_header(8'd7, 1);
		send_data();
		send_header(op_xor, 3);
		send_data();
		send_header(op_sum, 0);
		drain_results();
		// Reads stop for 30 cycles, so results pile up and push back on the host.
		@(negedge clock);
		pause_reads = 1'b1;
		fork
			begin
				for (int p = 0; p < 4; p++)
					send_packet(op_sum, 2);
			end
			begin
				repeat (20) @(posedge clock);
				repeat (10)
				begin
					@(posedge clock);
					#1;
					a_backed_up: assert (in_full)
						else halt_with_error("in_full fell while results were backed up.");
				end
				@(negedge clock);
				pause_reads = 1'b0;
			end
		join
		drain_results();
		if (expect_q.size() == 0 && results_seen == results_expected && !model_open)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
			halt_with_error("The run ended with results outstanding or a packet still open.");
	end

endmodule

/* fsl_accel_top.f */
design/fsl_accel_pkg.sv
design/fsl_link.sv
design/fsl_reduce_unit.sv
design/fsl_accel_ctrl.sv
design/fsl_accel_top.sv
tb/fsl_accel_tb.sv
